// ==== eightRam.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-line sprite evaluator: after each active row it scans
// the sprite RAM and keeps up to eight sprites for the next row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module eightRam #(
    parameter int gameStartY = 4
) (
    input  logic                              clkEightRam,
    input  logic                              rstn,
    input  logic                              gameWindow,
    input  ppuGeometryPkg::screenPosT         posY,
    output logic [spritePkg::oamAddrBits-1:0] oamRdAddr,
    input  spritePkg::spriteEntryT            oamRdData,
    spriteSlotIf.evaluator                    slotPort
);

    localparam int slotIdxBits = $clog2(spritePkg::slotNum);

    logic gameWindowD0;
    logic gameWindowD1;
    logic windowFall;
    logic rdEn;
    logic rdValid;
    logic [spritePkg::oamAddrBits-1:0] rdAddrCnt;
    ppuGeometryPkg::screenPosT rowNext;
    logic [8:0] rowExt;
    logic [8:0] bandTop;
    logic [8:0] bandEnd;
    logic inBand;
    logic slotWrite;
    logic lastAddr;
    logic lastSlot;

    // end of an active row
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            gameWindowD0 <= 1'b0;
            gameWindowD1 <= 1'b0;
            windowFall   <= 1'b0;
        end else begin
            gameWindowD0 <= gameWindow;
            gameWindowD1 <= gameWindowD0;
            windowFall   <= gameWindowD1 & ~gameWindowD0;
        end
    end

    assign rowNext = posY - ppuGeometryPkg::screenPosT'(gameStartY) +
                     ppuGeometryPkg::screenPosT'(1);

    // band test in 9 bits so yPos near 255 cannot wrap
    assign rowExt  = {1'b0, slotPort.targetRow};
    assign bandTop = {1'b0, oamRdData.yPos};
    assign bandEnd = bandTop + 9'(spritePkg::spriteHeight);
    assign inBand  = rowExt >= bandTop && rowExt < bandEnd;

    assign slotWrite = rdValid && inBand &&
        slotPort.slotCount < spritePkg::slotCountT'(spritePkg::slotNum);
    assign lastSlot = slotWrite &&
        slotPort.slotCount == spritePkg::slotCountT'(spritePkg::slotNum - 1);
    assign lastAddr = rdAddrCnt == spritePkg::oamAddrBits'(spritePkg::spriteNumMax - 1);

    assign oamRdAddr = rdAddrCnt;

    // address stream, one entry per cycle
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            rdEn      <= 1'b0;
            rdValid   <= 1'b0;
            rdAddrCnt <= '0;
        end else begin
            rdValid <= rdEn;
            if (windowFall) begin
                rdEn      <= 1'b1;
                rdAddrCnt <= '0;
            end else if (rdEn) begin
                if (lastAddr || lastSlot) begin
                    rdEn <= 1'b0;
                end else begin
                    rdAddrCnt <= rdAddrCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            slotPort.evalBusy  <= 1'b0;
            slotPort.slotCount <= '0;
            slotPort.targetRow <= '0;
        end else if (windowFall) begin
            slotPort.evalBusy  <= 1'b1;
            slotPort.slotCount <= '0;
            slotPort.targetRow <= rowNext[7:0];
        end else begin
            if (slotWrite) begin
                slotPort.slotCount <= slotPort.slotCount + 1'b1;
            end
            // last in-flight entry judged this cycle
            if (rdValid && !rdEn) begin
                slotPort.evalBusy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkEightRam) begin
        if (slotWrite) begin
            slotPort.slots[slotPort.slotCount[slotIdxBits-1:0]] <= oamRdData;
        end
    end

endmodule

// ==== ppuGeometryPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// screen and game-window coordinate widths and types,
// shared by the raster, evaluator and pixel path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ppuGeometryPkg;

    // screen counters cover the full raster incl. blanking
    parameter int screenPosBits = 10;

    // unsigned screen coordinate
    typedef logic [screenPosBits-1:0] screenPosT;

    // coordinate inside the 8-bit game window
    typedef logic [7:0] gamePosT;

endpackage

// ==== runSim.sh ====
#!/bin/sh
# build the sprite line testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spriteLineTb -f verilog.f -o simSpriteLine

if ! simOut="$(./obj_dir/simSpriteLine +verilator+error+limit+1000)"; then
    echo "$simOut"
    exit 1
fi
echo "$simOut"
echo "$simOut" | grep -qx '>>> PASS'

// ==== scanTiming.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster generator: free-running pixel and line counters
// plus the game-window level, all registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module scanTiming #(
    parameter int lineTotal = 160,
    parameter int frameLines = 32,
    parameter int gameStartX = 8,
    parameter int gameWidth = 64,
    parameter int gameStartY = 4,
    parameter int gameHeight = 24
) (
    input  logic                      clkEightRam,
    input  logic                      rstn,
    output ppuGeometryPkg::screenPosT posX,
    output ppuGeometryPkg::screenPosT posY,
    output logic                      gameWindow
);

    ppuGeometryPkg::screenPosT posXNext;
    ppuGeometryPkg::screenPosT posYNext;
    logic lineWrap;
    logic windowNext;

    assign lineWrap = posX == ppuGeometryPkg::screenPosT'(lineTotal - 1);
    assign posXNext = lineWrap ? '0 : posX + 1'b1;

    always_comb begin
        posYNext = posY;
        if (lineWrap) begin
            if (posY == ppuGeometryPkg::screenPosT'(frameLines - 1)) begin
                posYNext = '0;
            end else begin
                posYNext = posY + 1'b1;
            end
        end
    end

    // window decoded from the next position so it lines up with posX/posY
    assign windowNext =
        posXNext >= ppuGeometryPkg::screenPosT'(gameStartX) &&
        posXNext <  ppuGeometryPkg::screenPosT'(gameStartX + gameWidth) &&
        posYNext >= ppuGeometryPkg::screenPosT'(gameStartY) &&
        posYNext <  ppuGeometryPkg::screenPosT'(gameStartY + gameHeight);

    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            posX       <= '0;
            posY       <= '0;
            gameWindow <= 1'b0;
        end else begin
            posX       <= posXNext;
            posY       <= posYNext;
            gameWindow <= windowNext;
        end
    end

endmodule

// ==== spriteLineChecker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// monitor for the sprite line path that mirrors the sprite RAM,
// follows the raster and checks every pixel of the game window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spriteLineChecker #(
    parameter int lineTotal = 160,
    parameter int frameLines = 32,
    parameter int gameStartX = 8,
    parameter int gameWidth = 64,
    parameter int gameStartY = 4,
    parameter int gameHeight = 24
) (
    input  logic                              clkEightRam,
    input  logic                              rstn,
    input  logic                              oamWrEn,
    input  logic [spritePkg::oamAddrBits-1:0] oamWrAddr,
    input  spritePkg::spriteEntryT            oamWrData,
    input  ppuGeometryPkg::screenPosT         pixelX,
    input  ppuGeometryPkg::screenPosT         pixelY,
    input  logic                              gameWindow,
    input  logic                              spriteHit,
    input  logic [7:0]                        spriteTile,
    input  logic [7:0]                        spriteAttr,
    input  int                                expFrameHits,
    output int                                mismatchCount,
    output int                                pixelCount
);

    spritePkg::spriteEntryT ramModel [spritePkg::spriteNumMax];
    spritePkg::spriteEntryT predSlots [spritePkg::slotNum];
    int predCount;
    int frameHits;
    logic windowPrev;
    logic expWindow;
    // expected posX/posY now, and pixelX/pixelY which trail by one cycle
    int rasterX;
    int rasterY;
    int lastX;
    int lastY;

    always @(posedge clkEightRam) begin
        if (oamWrEn) begin
            ramModel[oamWrAddr] <= oamWrData;
        end
    end

    function automatic bit insideWindow(int x, int y);
        return x >= gameStartX && x < gameStartX + gameWidth &&
               y >= gameStartY && y < gameStartY + gameHeight;
    endfunction

    task automatic reportMismatch(string name, int got, int expected);
        mismatchCount++;
        $display("mismatch at %0t: %s got 0x%0h expected 0x%0h (pixel %0d,%0d)",
                 $time, name, got, expected, lastX, lastY);
    endtask

    // first slotNum sprites in index order whose band holds the target row
    task automatic predictSlots(int target);
        predCount = 0;
        for (int a = 0; a < spritePkg::spriteNumMax; a++) begin
            if (predCount < spritePkg::slotNum && target >= int'(ramModel[a].yPos) &&
                target < int'(ramModel[a].yPos) + spritePkg::spriteHeight) begin
                predSlots[predCount] = ramModel[a];
                predCount++;
            end
        end
    endtask

    task automatic checkRaster();
        if (pixelX !== ppuGeometryPkg::screenPosT'(lastX)) begin
            reportMismatch("pixelX", int'(pixelX), lastX);
        end
        if (pixelY !== ppuGeometryPkg::screenPosT'(lastY)) begin
            reportMismatch("pixelY", int'(pixelY), lastY);
        end
        if (gameWindow !== expWindow) begin
            reportMismatch("gameWindow", int'(gameWindow), int'(expWindow));
        end
    endtask

    task automatic checkPixel();
        int gx;
        logic expHit;
        spritePkg::spriteEntryT expEntry;
        expHit = 1'b0;
        expEntry = '0;
        if (insideWindow(lastX, lastY)) begin
            gx = lastX - gameStartX;
            pixelCount++;
            // first slot covering x wins
            for (int i = 0; i < predCount; i++) begin
                if (!expHit && int'(predSlots[i].xPos) <= gx &&
                    gx < int'(predSlots[i].xPos) + spritePkg::spriteHeight) begin
                    expHit = 1'b1;
                    expEntry = predSlots[i];
                end
            end
            if (spriteHit === 1'b1) begin
                frameHits++;
            end
        end
        if (spriteHit !== expHit) begin
            reportMismatch("spriteHit", int'(spriteHit), int'(expHit));
        end else if (expHit) begin
            if (spriteTile !== expEntry.tile) begin
                reportMismatch("spriteTile", int'(spriteTile), int'(expEntry.tile));
            end
            if (spriteAttr !== expEntry.attr) begin
                reportMismatch("spriteAttr", int'(spriteAttr), int'(expEntry.attr));
            end
        end
    endtask

    // compared on the falling edge with all registers settled
    always @(negedge clkEightRam) begin
        if (!rstn) begin
            mismatchCount = 0;
            pixelCount = 0;
            predCount = 0;
            frameHits = 0;
            windowPrev = 1'b0;
            rasterX = 0;
            rasterY = 0;
            lastX = 0;
            lastY = 0;
        end else begin
            expWindow = insideWindow(rasterX, rasterY);
            checkRaster();
            checkPixel();
            // row just ended so evaluation targets the next one
            // row 0 keeps what the last row of the frame before evaluated
            if (windowPrev && !expWindow) begin
                predictSlots((lastY - gameStartY + 1) & 255);
            end
            if (lastY == gameStartY + gameHeight && lastX == 0) begin
                if (expFrameHits >= 0 && frameHits != expFrameHits) begin
                    reportMismatch("frameHits", frameHits, expFrameHits);
                end
                frameHits = 0;
            end
            windowPrev = expWindow;
            lastX = rasterX;
            lastY = rasterY;
            // free-running raster wrapping per line and per frame
            if (rasterX == lineTotal - 1) begin
                rasterX = 0;
                rasterY = (rasterY == frameLines - 1) ? 0 : rasterY + 1;
            end else begin
                rasterX++;
            end
        end
    end

endmodule

// ==== spriteLineSva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions on the sprite evaluator slot bus,
// bound into every eightRam instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spriteLineSva (
    input logic                   clkEightRam,
    input logic                   rstn,
    input logic                   evalBusy,
    input spritePkg::slotCountT   slotCount,
    input spritePkg::spriteEntryT slots [spritePkg::slotNum]
);

    logic [32*spritePkg::slotNum-1:0] slotsFlat;
    int busyCycles;
    int countFails = 0;
    int stableFails = 0;
    int latencyFails = 0;

    always_comb begin
        for (int i = 0; i < spritePkg::slotNum; i++) begin
            slotsFlat[i*32 +: 32] = slots[i];
        end
    end

    // cycles spent with evalBusy high
    always_ff @(posedge clkEightRam) begin
        if (!rstn || !evalBusy) begin
            busyCycles <= 0;
        end else begin
            busyCycles <= busyCycles + 1;
        end
    end

    countLimit: assert property (@(posedge clkEightRam) disable iff (!rstn)
        slotCount <= spritePkg::slotCountT'(spritePkg::slotNum))
    else begin
        $error("slotCount exceeds the number of slots");
        countFails++;
    end

    slotsHold: assert property (@(posedge clkEightRam) disable iff (!rstn)
        (!evalBusy && !$past(evalBusy)) |-> ($stable(slotsFlat) && $stable(slotCount)))
    else begin
        $error("slots changed while the evaluator was idle");
        stableFails++;
    end

    busyLatency: assert property (@(posedge clkEightRam) disable iff (!rstn)
        busyCycles < 70)
    else begin
        $error("evalBusy stayed high for 70 cycles");
        latencyFails++;
    end

endmodule

bind eightRam spriteLineSva assertChecks (
    .clkEightRam(clkEightRam),
    .rstn       (rstn),
    .evalBusy   (slotPort.evalBusy),
    .slotCount  (slotPort.slotCount),
    .slots      (slotPort.slots)
);

// ==== spriteLineTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sprite line path that loads sprite sets
// in vertical blank from a table and runs frames per set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spriteLineTb;

    localparam int lineTotal = 160;
    localparam int frameLines = 32;
    localparam int gameStartX = 8;
    localparam int gameWidth = 64;
    localparam int gameStartY = 4;
    localparam int gameHeight = 24;
    localparam int waitLimit = 2 * lineTotal * frameLines;
    localparam int numRows = 6;
    localparam int numWrites = 21;

    // frames to run, hits per frame (-1 unchecked) and random fill per set
    localparam int rowFrames [numRows] = '{2, 2, 2, 2, 2, 3};
    localparam int rowExpHits [numRows] = '{64, 104, 400, 128, 32, -1};
    localparam bit rowRandomFill [numRows] = '{0, 0, 0, 0, 0, 1};

    // set, address, xPos, yPos, tile, attr
    localparam logic [47:0] writeTable [numWrites] = '{
        {8'd0, 8'd5,  8'd10,  8'd6,   8'h21, 8'h03},
        {8'd1, 8'd2,  8'd20,  8'd3,   8'h31, 8'h01},
        {8'd1, 8'd3,  8'd24,  8'd5,   8'h32, 8'h02},
        {8'd2, 8'd10, 8'd0,   8'd12,  8'h40, 8'h00},
        {8'd2, 8'd11, 8'd6,   8'd12,  8'h41, 8'h01},
        {8'd2, 8'd12, 8'd12,  8'd12,  8'h42, 8'h02},
        {8'd2, 8'd13, 8'd18,  8'd12,  8'h43, 8'h03},
        {8'd2, 8'd14, 8'd24,  8'd12,  8'h44, 8'h04},
        {8'd2, 8'd15, 8'd30,  8'd12,  8'h45, 8'h05},
        {8'd2, 8'd16, 8'd36,  8'd12,  8'h46, 8'h06},
        {8'd2, 8'd17, 8'd42,  8'd12,  8'h47, 8'h07},
        {8'd2, 8'd18, 8'd48,  8'd12,  8'h48, 8'h08},
        {8'd2, 8'd19, 8'd54,  8'd12,  8'h49, 8'h09},
        {8'd3, 8'd0,  8'd30,  8'd2,   8'h51, 8'h10},
        {8'd3, 8'd1,  8'd40,  8'd14,  8'h52, 8'h20},
        {8'd4, 8'd4,  8'd10,  8'd250, 8'h61, 8'h30},
        {8'd4, 8'd6,  8'd20,  8'd255, 8'h62, 8'h31},
        {8'd4, 8'd7,  8'd70,  8'd8,   8'h63, 8'h32},
        {8'd4, 8'd8,  8'd250, 8'd8,   8'h64, 8'h33},
        {8'd4, 8'd9,  8'd60,  8'd8,   8'h65, 8'h34},
        {8'd5, 8'd0,  8'd0,   8'd1,   8'h5a, 8'ha5}
    };

    logic clkEightRam;
    logic rstn;
    logic oamWrEn;
    logic [spritePkg::oamAddrBits-1:0] oamWrAddr;
    spritePkg::spriteEntryT oamWrData;
    ppuGeometryPkg::screenPosT pixelX;
    ppuGeometryPkg::screenPosT pixelY;
    logic gameWindow;
    logic spriteHit;
    logic [7:0] spriteTile;
    logic [7:0] spriteAttr;
    int expFrameHits;
    int mismatchCount;
    int pixelCount;
    int timeoutCount;
    int assertFails;
    bit timedOut;

    spriteLineTop #(
        .lineTotal (lineTotal),
        .frameLines(frameLines),
        .gameStartX(gameStartX),
        .gameWidth (gameWidth),
        .gameStartY(gameStartY),
        .gameHeight(gameHeight)
    ) DUT (
        .clkEightRam(clkEightRam),
        .rstn       (rstn),
        .oamWrEn    (oamWrEn),
        .oamWrAddr  (oamWrAddr),
        .oamWrData  (oamWrData),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .gameWindow (gameWindow),
        .spriteHit  (spriteHit),
        .spriteTile (spriteTile),
        .spriteAttr (spriteAttr)
    );

    spriteLineChecker #(
        .lineTotal (lineTotal),
        .frameLines(frameLines),
        .gameStartX(gameStartX),
        .gameWidth (gameWidth),
        .gameStartY(gameStartY),
        .gameHeight(gameHeight)
    ) pixelCheck (
        .clkEightRam  (clkEightRam),
        .rstn         (rstn),
        .oamWrEn      (oamWrEn),
        .oamWrAddr    (oamWrAddr),
        .oamWrData    (oamWrData),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .gameWindow   (gameWindow),
        .spriteHit    (spriteHit),
        .spriteTile   (spriteTile),
        .spriteAttr   (spriteAttr),
        .expFrameHits (expFrameHits),
        .mismatchCount(mismatchCount),
        .pixelCount   (pixelCount)
    );

    initial begin
        clkEightRam = 1'b0;
        forever begin
            #5 clkEightRam = ~clkEightRam;
        end
    end

    // one write per cycle starting 1 ns after a rising edge
    task automatic writeEntry(logic [spritePkg::oamAddrBits-1:0] addr,
                              spritePkg::spriteEntryT entry);
        oamWrEn = 1'b1;
        oamWrAddr = addr;
        oamWrData = entry;
        @(posedge clkEightRam);
        #1;
        oamWrEn = 1'b0;
    endtask

    // every entry parked off the game window
    task automatic clearRam();
        for (int a = 0; a < spritePkg::spriteNumMax; a++) begin
            writeEntry(spritePkg::oamAddrBits'(a), {8'd200, 8'd200, 8'h00, 8'h00});
        end
    endtask

    // crowded filler of about sixteen sprites per row
    function automatic spritePkg::spriteEntryT makeRandomEntry();
        spritePkg::spriteEntryT entry;
        entry = $urandom;
        entry.xPos = 8'($urandom % 80);
        entry.yPos = 8'($urandom % 32);
        return entry;
    endfunction

    task automatic waitVblank();
        bit found;
        found = 1'b0;
        for (int cycles = 0; cycles < waitLimit && !found; cycles++) begin
            @(posedge clkEightRam);
            #1;
            found = int'(pixelY) == gameStartY + gameHeight && pixelX == '0;
        end
        if (!found) begin
            timeoutCount++;
            timedOut = 1'b1;
            $display("timeout: no vertical blank start within %0d cycles", waitLimit);
        end
    endtask

    task automatic writeRow(int r);
        logic [47:0] w;
        clearRam();
        if (rowRandomFill[r]) begin
            for (int a = 0; a < spritePkg::spriteNumMax; a++) begin
                writeEntry(spritePkg::oamAddrBits'(a), makeRandomEntry());
            end
        end
        for (int i = 0; i < numWrites; i++) begin
            w = writeTable[i];
            if (int'(w[47:40]) == r) begin
                writeEntry(w[37:32], w[31:0]);
            end
        end
        expFrameHits = rowExpHits[r];
    endtask

    initial begin
        void'($urandom(32'h8463_e5e4));
        rstn = 1'b0;
        oamWrEn = 1'b0;
        oamWrAddr = '0;
        oamWrData = '0;
        expFrameHits = -1;
        timeoutCount = 0;
        timedOut = 1'b0;
        repeat (5) @(posedge clkEightRam);
        #1;
        rstn = 1'b1;
        // sprite RAM has no reset so it is filled before the first row ends
        clearRam();
        for (int r = 0; r < numRows && !timedOut; r++) begin
            waitVblank();
            if (!timedOut) begin
                writeRow(r);
                for (int f = 0; f < rowFrames[r] && !timedOut; f++) begin
                    waitVblank();
                end
            end
        end
        assertFails = DUT.uEightRam.assertChecks.countFails +
                      DUT.uEightRam.assertChecks.stableFails +
                      DUT.uEightRam.assertChecks.latencyFails;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures, %0d pixels",
                 mismatchCount, timeoutCount, assertFails, pixelCount);
        if (mismatchCount == 0 && timeoutCount == 0 && assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== spriteLineTop.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite line path top: raster timing, sprite RAM,
// line evaluator and pixel selector behind plain ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spriteLineTop #(
    parameter int lineTotal = 160,
    parameter int frameLines = 32,
    parameter int gameStartX = 8,
    parameter int gameWidth = 64,
    parameter int gameStartY = 4,
    parameter int gameHeight = 24
) (
    input  logic                              clkEightRam,
    input  logic                              rstn,
    input  logic                              oamWrEn,
    input  logic [spritePkg::oamAddrBits-1:0] oamWrAddr,
    input  spritePkg::spriteEntryT            oamWrData,
    output ppuGeometryPkg::screenPosT         pixelX,
    output ppuGeometryPkg::screenPosT         pixelY,
    output logic                              gameWindow,
    output logic                              spriteHit,
    output logic [7:0]                        spriteTile,
    output logic [7:0]                        spriteAttr
);

    ppuGeometryPkg::screenPosT posX;
    ppuGeometryPkg::screenPosT posY;
    logic [spritePkg::oamAddrBits-1:0] oamRdAddr;
    spritePkg::spriteEntryT oamRdData;

    spriteSlotIf slotBus ();

    scanTiming #(
        .lineTotal (lineTotal),
        .frameLines(frameLines),
        .gameStartX(gameStartX),
        .gameWidth (gameWidth),
        .gameStartY(gameStartY),
        .gameHeight(gameHeight)
    ) uScanTiming (
        .clkEightRam(clkEightRam),
        .rstn       (rstn),
        .posX       (posX),
        .posY       (posY),
        .gameWindow (gameWindow)
    );

    spriteRam uSpriteRam (
        .clkEightRam(clkEightRam),
        .wrEn       (oamWrEn),
        .wrAddr     (oamWrAddr),
        .rdAddr     (oamRdAddr),
        .wrData     (oamWrData),
        .rdData     (oamRdData)
    );

    eightRam #(
        .gameStartY(gameStartY)
    ) uEightRam (
        .clkEightRam(clkEightRam),
        .rstn       (rstn),
        .gameWindow (gameWindow),
        .posY       (posY),
        .oamRdAddr  (oamRdAddr),
        .oamRdData  (oamRdData),
        .slotPort   (slotBus.evaluator)
    );

    spritePixelMux #(
        .gameStartX(gameStartX)
    ) uSpritePixelMux (
        .clkEightRam(clkEightRam),
        .rstn       (rstn),
        .gameWindow (gameWindow),
        .posX       (posX),
        .posY       (posY),
        .slotPort   (slotBus.drawer),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .spriteHit  (spriteHit),
        .spriteTile (spriteTile),
        .spriteAttr (spriteAttr)
    );

endmodule

// ==== spritePixelMux.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite pixel selector: per game pixel picks the lowest live
// slot covering x, output registered one cycle behind posX/posY
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spritePixelMux #(
    parameter int gameStartX = 8
) (
    input  logic                      clkEightRam,
    input  logic                      rstn,
    input  logic                      gameWindow,
    input  ppuGeometryPkg::screenPosT posX,
    input  ppuGeometryPkg::screenPosT posY,
    spriteSlotIf.drawer               slotPort,
    output ppuGeometryPkg::screenPosT pixelX,
    output ppuGeometryPkg::screenPosT pixelY,
    output logic                      spriteHit,
    output logic [7:0]                spriteTile,
    output logic [7:0]                spriteAttr
);

    localparam int slotIdxBits = $clog2(spritePkg::slotNum);

    ppuGeometryPkg::screenPosT gameX;
    logic found;
    logic [slotIdxBits-1:0] sel;

    assign gameX = posX - ppuGeometryPkg::screenPosT'(gameStartX);

    // walk down so the lowest index wins
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = spritePkg::slotNum - 1; i >= 0; i--) begin
            if (spritePkg::slotCountT'(i) < slotPort.slotCount &&
                {2'b00, slotPort.slots[i].xPos} <= gameX &&
                {2'b00, slotPort.slots[i].xPos} +
                    ppuGeometryPkg::screenPosT'(spritePkg::spriteHeight) > gameX) begin
                found = 1'b1;
                sel   = slotIdxBits'(i);
            end
        end
    end

    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            spriteHit <= 1'b0;
        end else begin
            spriteHit <= gameWindow & found;
        end
    end

    always_ff @(posedge clkEightRam) begin
        pixelX     <= posX;
        pixelY     <= posY;
        spriteTile <= slotPort.slots[sel].tile;
        spriteAttr <= slotPort.slots[sel].attr;
    end

endmodule

// ==== spritePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite table layout and sizes,
// used by the sprite RAM, evaluator and pixel selector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package spritePkg;

    // sprite attribute RAM depth
    parameter int spriteNumMax = 64;
    parameter int oamAddrBits = $clog2(spriteNumMax);

    // sprites kept per game row
    parameter int slotNum = 8;

    // 0 to slotNum filled slots
    typedef logic [3:0] slotCountT;

    // sprites are square
    parameter int spriteHeight = 8;

    // one 32-bit sprite table word
    typedef struct packed {
        logic [7:0] xPos;
        logic [7:0] yPos;
        logic [7:0] tile;
        logic [7:0] attr;
    } spriteEntryT;

endpackage

// ==== spriteRam.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite attribute RAM, CPU write port and
// one-cycle synchronous read port for the evaluator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spriteRam (
    input  logic                               clkEightRam,
    input  logic                               wrEn,
    input  logic [spritePkg::oamAddrBits-1:0]  wrAddr,
    input  logic [spritePkg::oamAddrBits-1:0]  rdAddr,
    input  spritePkg::spriteEntryT             wrData,
    output spritePkg::spriteEntryT             rdData
);

    spritePkg::spriteEntryT mem [spritePkg::spriteNumMax];

    // write on the strobe edge
    always_ff @(posedge clkEightRam) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, data valid the cycle after rdAddr
    always_ff @(posedge clkEightRam) begin
        rdData <= mem[rdAddr];
    end

endmodule

// ==== spriteSlotIf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite slots of the next game row,
// filled by the evaluator and read by the pixel selector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface spriteSlotIf;

    // kept sprites in sprite RAM index order
    spritePkg::spriteEntryT slots [spritePkg::slotNum];
    // only slots below this count are live
    spritePkg::slotCountT slotCount;
    ppuGeometryPkg::gamePosT targetRow;
    // slots are stable while this is low
    logic evalBusy;

    modport evaluator (
        output slots, slotCount, targetRow, evalBusy
    );

    modport drawer (
        input slots, slotCount, targetRow, evalBusy
    );

endinterface

// ==== verilog.f ====
ppuGeometryPkg.sv
spritePkg.sv
spriteSlotIf.sv
scanTiming.sv
spriteRam.sv
eightRam.sv
spritePixelMux.sv
spriteLineTop.sv
spriteLineChecker.sv
spriteLineSva.sv
spriteLineTb.sv
